/* wiscCore.f */
+incdir+.
wiscPkg.sv
instrDecode.sv
regFile.sv
alu.sv
flowControl.sv
wiscCore.sv
wiscCoreTb.sv

/* wiscRefModel.svh */
`ifndef WISC_REF_MODEL_SVH
`define WISC_REF_MODEL_SVH

// Architectural state of the model
wiscPkg::word_t  refRegs [wiscPkg::regCnt];
wiscPkg::word_t  refMem [1 << wiscPkg::dataW];
wiscPkg::word_t  refPc;
wiscPkg::flags_t refFlags;
logic            refHalted;

// Back to the reset state
// Data memory is loaded separately
function automatic void resetModel();
  foreach (refRegs[i]) refRegs[i] = '0;
  refPc = '0;
  refFlags = '0;
  refHalted = 1'b0;
endfunction

// Runs one instruction and returns the expected core outputs
// memAddr only matters for lw and sw
// memWData only matters for sw
function automatic void stepModel(
  input  wiscPkg::word_t  instr,
  output wiscPkg::trace_t expTrace,
  output logic            expMemWe,
  output logic            expMemRe,
  output wiscPkg::word_t  expMemAddr,
  output wiscPkg::word_t  expMemWData
);
  wiscPkg::opcode_t op;
  wiscPkg::word_t   a;
  wiscPkg::word_t   b;
  wiscPkg::word_t   res;
  wiscPkg::word_t   nextPc;
  logic             taken;
  logic             ov;
  op = wiscPkg::opcode_t'(instr[15:12]);
  a = refRegs[instr[7:4]];
  b = refRegs[instr[3:0]];
  expTrace = '0;
  expTrace.pc = refPc;
  expTrace.wrAddr = instr[11:8];
  expMemWe = 1'b0;
  expMemRe = 1'b0;
  expMemAddr = a + {{12{instr[3]}}, instr[3:0]};
  expMemWData = refRegs[instr[11:8]];
  if (refHalted) return;
  expTrace.valid = 1'b1;
  nextPc = refPc + 16'd1;
  case (op)
    wiscPkg::opLw: begin
      expMemRe = 1'b1;
      expTrace.wrEn = 1'b1;
      expTrace.wrData = refMem[expMemAddr];
    end
    wiscPkg::opSw: begin
      expMemWe = 1'b1;
      refMem[expMemAddr] = expMemWData;
    end
    wiscPkg::opLhb: begin
      expTrace.wrEn = 1'b1;
      expTrace.wrData = {instr[7:0], expMemWData[7:0]};
    end
    wiscPkg::opLlb: begin
      expTrace.wrEn = 1'b1;
      expTrace.wrData = {{8{instr[7]}}, instr[7:0]};
    end
    wiscPkg::opB: begin
      case (instr[11:9])
        3'd0: taken = !refFlags.z;
        3'd1: taken = refFlags.z;
        3'd2: taken = !refFlags.z && !refFlags.n;
        3'd3: taken = refFlags.n;
        3'd4: taken = refFlags.z || !refFlags.n;
        3'd5: taken = refFlags.n || refFlags.z;
        3'd6: taken = refFlags.v;
        default: taken = 1'b1;
      endcase
      if (taken) nextPc = nextPc + {{7{instr[8]}}, instr[8:0]};
    end
    wiscPkg::opJal: begin
      expTrace.wrEn = 1'b1;
      expTrace.wrAddr = wiscPkg::regAddr_t'(wiscPkg::linkReg);
      expTrace.wrData = nextPc;
      nextPc = nextPc + {{4{instr[11]}}, instr[11:0]};
    end
    wiscPkg::opJr: nextPc = a;
    wiscPkg::opHlt: begin
      refHalted = 1'b1;
      nextPc = refPc;
    end
    default: begin
      // ALU group including addz
      case (op)
        wiscPkg::opSub: res = a - b;
        wiscPkg::opAnd: res = a & b;
        wiscPkg::opNor: res = ~(a | b);
        wiscPkg::opSll: res = a << instr[3:0];
        wiscPkg::opSrl: res = a >> instr[3:0];
        wiscPkg::opSra: res = $signed(a) >>> instr[3:0];
        default: res = a + b;
      endcase
      if (op == wiscPkg::opSub) ov = (a[15] != b[15]) && (res[15] != a[15]);
      else if (op == wiscPkg::opAdd || op == wiscPkg::opAddz)
        ov = (a[15] == b[15]) && (res[15] != a[15]);
      else ov = 1'b0;
      // addz retires without effect when Z is clear
      if (op != wiscPkg::opAddz || refFlags.z) begin
        expTrace.wrEn = 1'b1;
        expTrace.wrData = res;
        refFlags = '{z: (res == '0), v: ov, n: res[15]};
      end
    end
  endcase
  if (expTrace.wrEn && expTrace.wrAddr != '0) refRegs[expTrace.wrAddr] = expTrace.wrData;
  refPc = nextPc;
endfunction

`endif

/* wiscCoreTb.sv */
`timescale 1ns/10ps

module wiscCoreTb;
  import wiscPkg::*;

  logic   clk;
  logic   rstN;
  word_t  pc;
  word_t  instr;
  word_t  memAddr;
  word_t  memWData;
  word_t  memRData;
  logic   memWe;
  logic   memRe;
  trace_t trace;

  // Instruction and data memories
  word_t imem [65536];
  word_t dmem [65536];

  // Expected outputs for the instruction in flight
  trace_t expTrace;
  logic   expMemWe;
  logic   expMemRe;
  word_t  expMemAddr;
  word_t  expMemWData;

  logic [31:0] lfsrState;
  logic        checking;
  int          progLen;
  int          errCount;
  int          failCount;
  int          testNum;

  `include "wiscRefModel.svh"

  wiscCore u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .pc       (pc),
    .instr    (instr),
    .memAddr  (memAddr),
    .memWData (memWData),
    .memRData (memRData),
    .memWe    (memWe),
    .memRe    (memRe),
    .trace    (trace)
  );

  always #5 clk = ~clk;

  // Fetch 1 ns after each edge
  always @(posedge clk) begin
    #1;
    instr <= imem[pc];
  end

  // Combinational data read
  assign memRData = dmem[memAddr];

  // Stores land at the edge, held off during reset
  always @(posedge clk) begin
    if (rstN && memWe) begin
      dmem[memAddr] <= memWData;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] randBits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsrBit()};
    end
    return v;
  endfunction

  // Opcode plus three nibbles covers every format but b
  function automatic word_t instrWord(opcode_t op, logic [3:0] f2, logic [3:0] f1,
                                      logic [3:0] f0);
    return {op, f2, f1, f0};
  endfunction

  function automatic word_t branchWord(logic [2:0] cond, logic [8:0] off);
    return {opB, cond, off};
  endfunction

  task automatic checkField(string name, logic [15:0] got, logic [15:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  // Compare against the model once per cycle, mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (checking) begin
      stepModel(imem[refPc], expTrace, expMemWe, expMemRe, expMemAddr, expMemWData);
      checkField("trace.valid", trace.valid, expTrace.valid);
      checkField("trace.pc", trace.pc, expTrace.pc);
      checkField("trace.wrEn", trace.wrEn, expTrace.wrEn);
      checkField("memWe", memWe, expMemWe);
      checkField("memRe", memRe, expMemRe);
      if (expTrace.wrEn) begin
        checkField("trace.wrAddr", trace.wrAddr, expTrace.wrAddr);
        checkField("trace.wrData", trace.wrData, expTrace.wrData);
      end
      if (expMemWe || expMemRe) begin
        checkField("memAddr", memAddr, expMemAddr);
      end
      if (expMemWe) begin
        checkField("memWData", memWData, expMemWData);
      end
    end
  end

  // Unused space holds hlt
  task automatic clearProgram();
    for (int i = 0; i < 65536; i++) begin
      imem[i] = instrWord(opHlt, 4'h0, 4'h0, 4'h0);
    end
    progLen = 0;
  endtask

  task automatic emit(word_t w);
    imem[progLen] = w;
    progLen++;
  endtask

  // llb then lhb
  task automatic loadConst(logic [3:0] rd, word_t value);
    emit(instrWord(opLlb, rd, value[7:4], value[3:0]));
    emit(instrWord(opLhb, rd, value[15:12], value[11:8]));
  endtask

  task automatic aluProgram();
    logic [2:0] code;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    clearProgram();
    for (int r = 1; r < 16; r++) begin
      loadConst(r[3:0], randBits(16));
    end
    for (int i = 0; i < 200; i++) begin
      code = 3'(randBits(3));
      rd = 4'(randBits(4));
      rs = 4'(randBits(4));
      rt = 4'(randBits(4));
      // Code 1 is addz, fold it onto add
      emit(instrWord(opcode_t'({1'b0, (code == 3'd1) ? 3'd0 : code}), rd, rs, rt));
    end
    // Add and sub that wrap and set V, each followed by b ov
    loadConst(4'd1, 16'h7fff);
    loadConst(4'd2, 16'h0001);
    emit(instrWord(opAdd, 4'd3, 4'd1, 4'd2));
    emit(branchWord(3'd6, 9'd1));
    emit(instrWord(opLlb, 4'd4, 4'h1, 4'h1));
    loadConst(4'd5, 16'h8000);
    emit(instrWord(opSub, 4'd6, 4'd5, 4'd2));
    emit(branchWord(3'd6, 9'd1));
    emit(instrWord(opLlb, 4'd4, 4'h2, 4'h2));
  endtask

  task automatic immProgram();
    logic [3:0] rd;
    clearProgram();
    for (int i = 0; i < 16; i++) begin
      rd = 4'(randBits(4));
      if (rd == 4'd0) rd = 4'd1;
      loadConst(rd, randBits(16));
    end
  endtask

  task automatic memProgram();
    clearProgram();
    loadConst(4'd1, randBits(16));
    for (int r = 2; r < 6; r++) begin
      loadConst(r[3:0], randBits(16));
    end
    // Offsets -8, 7, -1 and 0 around the base in R1
    emit(instrWord(opSw, 4'd2, 4'd1, 4'h8));
    emit(instrWord(opSw, 4'd3, 4'd1, 4'h7));
    emit(instrWord(opSw, 4'd4, 4'd1, 4'hf));
    emit(instrWord(opSw, 4'd5, 4'd1, 4'h0));
    emit(instrWord(opLw, 4'd6, 4'd1, 4'h8));
    emit(instrWord(opLw, 4'd7, 4'd1, 4'h7));
    emit(instrWord(opLw, 4'd8, 4'd1, 4'hf));
    emit(instrWord(opLw, 4'd9, 4'd1, 4'h0));
    // Untouched word from the fill pattern
    emit(instrWord(opLw, 4'd10, 4'd1, 4'h3));
    emit(instrWord(opSw, 4'd2, 4'd0, 4'h5));
    emit(instrWord(opLw, 4'd11, 4'd0, 4'h5));
  endtask

  task automatic branchProgram();
    word_t setup [4];
    clearProgram();
    loadConst(4'd1, 16'h0001);
    loadConst(4'd2, 16'hffff);
    loadConst(4'd3, 16'h7fff);
    // Flag states Z, none, N and V with N
    setup[0] = instrWord(opSub, 4'd4, 4'd1, 4'd1);
    setup[1] = instrWord(opAdd, 4'd4, 4'd1, 4'd0);
    setup[2] = instrWord(opAdd, 4'd4, 4'd2, 4'd0);
    setup[3] = instrWord(opAdd, 4'd4, 4'd3, 4'd1);
    for (int c = 0; c < 8; c++) begin
      for (int s = 0; s < 4; s++) begin
        emit(setup[s]);
        emit(branchWord(c[2:0], 9'd1));
        emit(instrWord(opLlb, 4'd5, c[3:0], s[3:0]));
      end
    end
    // Count R6 down to zero with a backward bne
    emit(instrWord(opLlb, 4'd6, 4'h0, 4'h5));
    emit(instrWord(opLlb, 4'd7, 4'h0, 4'h1));
    emit(instrWord(opSub, 4'd6, 4'd6, 4'd7));
    emit(branchWord(3'd0, 9'h1fe));
  endtask

  task automatic callProgram();
    clearProgram();
    emit(instrWord(opLlb, 4'd1, 4'h0, 4'h5));
    // Call to 8, returns to 2
    emit(instrWord(opJal, 4'h0, 4'h0, 4'h6));
    emit(instrWord(opLlb, 4'd8, 4'h0, 4'hc));
    emit(instrWord(opJr, 4'h0, 4'd8, 4'h0));
    progLen = 8;
    emit(instrWord(opAdd, 4'd4, 4'd1, 4'd1));
    emit(instrWord(opJr, 4'h0, 4'd15, 4'h0));
    emit(instrWord(opLlb, 4'd10, 4'h5, 4'h5));
    emit(instrWord(opHlt, 4'h0, 4'h0, 4'h0));
    emit(instrWord(opLlb, 4'd9, 4'h4, 4'h4));
    // Backward jal from 13 to 10
    emit(instrWord(opJal, 4'hf, 4'hf, 4'hc));
  endtask

  task automatic addzProgram();
    clearProgram();
    emit(instrWord(opLlb, 4'd1, 4'h0, 4'h3));
    emit(instrWord(opLlb, 4'd2, 4'h0, 4'h4));
    emit(instrWord(opSub, 4'd3, 4'd1, 4'd1));
    emit(instrWord(opAddz, 4'd4, 4'd1, 4'd2));
    emit(instrWord(opAddz, 4'd5, 4'd1, 4'd2));
    emit(instrWord(opAdd, 4'd6, 4'd1, 4'd0));
    emit(instrWord(opAddz, 4'd7, 4'd1, 4'd2));
    emit(instrWord(opSub, 4'd3, 4'd2, 4'd2));
    emit(instrWord(opAddz, 4'd7, 4'd1, 4'd2));
  endtask

  task automatic runProgram(string name);
    int    startErr;
    logic  done;
    word_t haltPc;
    startErr = errCount;
    testNum++;
    for (int i = 0; i < 65536; i++) begin
      dmem[i] = word_t'(i * 40503) ^ 16'h5aa5;
      refMem[i] = dmem[i];
    end
    @(posedge clk);
    #1;
    checking = 1'b0;
    rstN = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    resetModel();
    checking = 1'b1;
    done = 1'b0;
    for (int cyc = 0; cyc < 2000 && !done; cyc++) begin
      @(negedge clk);
      if (!trace.valid) done = 1'b1;
    end
    if (!done) begin
      $display("Program %s: program did not halt within 2000 cycles", name);
      errCount++;
    end else begin
      // pc, valid and stores must stay frozen
      // A store replaces the hlt so only the halted state keeps the core still
      haltPc = pc;
      imem[haltPc] = instrWord(opSw, 4'd1, 4'd0, 4'h0);
      for (int i = 0; i < 20; i++) begin
        @(negedge clk);
        assert (trace.valid === 1'b0 && pc === haltPc && memWe === 1'b0) else begin
          $display("Program %s: core left the halted state at %0t", name, $time);
          errCount++;
        end
      end
    end
    @(posedge clk);
    #1;
    checking = 1'b0;
    if (errCount != startErr) failCount++;
    $display("Test %0d %s: %s, %0d errors", testNum, name,
             (errCount == startErr) ? "ok" : "FAILED", errCount - startErr);
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    instr = '0;
    checking = 1'b0;
    errCount = 0;
    failCount = 0;
    testNum = 0;
    lfsrState = 32'hadfb7090;
    aluProgram();
    runProgram("alu");
    immProgram();
    runProgram("immediates");
    memProgram();
    runProgram("memory");
    branchProgram();
    runProgram("branches");
    callProgram();
    runProgram("jal/jr");
    addzProgram();
    runProgram("addz/hlt");
    $display("Totals: %0d tests, %0d failed, %0d errors", testNum, failCount, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* wiscCore.sv */
`timescale 1ns/10ps

module wiscCore (
  input  logic            clk,
  input  logic            rstN,
  output wiscPkg::word_t  pc,
  input  wiscPkg::word_t  instr,
  output wiscPkg::word_t  memAddr,
  output wiscPkg::word_t  memWData,
  input  wiscPkg::word_t  memRData,
  output logic            memWe,
  output logic            memRe,
  output wiscPkg::trace_t trace
);
  import wiscPkg::*;

  regAddr_t p0Addr;
  regAddr_t p1Addr;
  regAddr_t regAddr;
  word_t    imm;
  logic [3:0] shamt;
  brCond_t  brCond;
  ctrl_t    ctrl;
  word_t    p0;
  word_t    p1;
  word_t    aluResult;
  flags_t   nextFlags;
  word_t    linkAddr;
  word_t    wrData;
  logic     writeAllow;
  logic     halted;

  instrDecode u_decode (
    .instr   (instr),
    .p0Addr  (p0Addr),
    .p1Addr  (p1Addr),
    .regAddr (regAddr),
    .imm     (imm),
    .shamt   (shamt),
    .brCond  (brCond),
    .ctrl    (ctrl)
  );

  regFile u_regs (
    .clk        (clk),
    .rstN       (rstN),
    .p0Addr     (p0Addr),
    .p1Addr     (p1Addr),
    .p0         (p0),
    .p1         (p1),
    .wrAddr     (regAddr),
    .wrData     (wrData),
    .regWe      (ctrl.regWe),
    .writeAllow (writeAllow)
  );

  alu u_alu (
    .p0        (p0),
    .p1        (p1),
    .imm       (imm),
    .shamt     (shamt),
    .ctrl      (ctrl),
    .result    (aluResult),
    .nextFlags (nextFlags)
  );

  // jr jumps to the value in source 0
  flowControl u_flow (
    .clk        (clk),
    .rstN       (rstN),
    .ctrl       (ctrl),
    .brCond     (brCond),
    .imm        (imm),
    .jrTarget   (p0),
    .nextFlags  (nextFlags),
    .pc         (pc),
    .linkAddr   (linkAddr),
    .writeAllow (writeAllow),
    .halted     (halted)
  );

  // Write-back source
  assign wrData = ctrl.memToReg ? memRData : (ctrl.jal ? linkAddr : aluResult);

  // Address is base plus offset from the ALU
  assign memAddr  = aluResult;
  assign memWData = p1;
  assign memWe    = ctrl.memWe && !halted;
  assign memRe    = ctrl.memRe && !halted;

  // Retirement view of the current instruction
  assign trace = '{
    valid:  !halted,
    pc:     pc,
    wrEn:   ctrl.regWe && writeAllow,
    wrAddr: regAddr,
    wrData: wrData
  };

endmodule

/* flowControl.sv */
`timescale 1ns/10ps

module flowControl (
  input  logic             clk,
  input  logic             rstN,
  input  wiscPkg::ctrl_t   ctrl,
  input  wiscPkg::brCond_t brCond,
  input  wiscPkg::word_t   imm,
  input  wiscPkg::word_t   jrTarget,
  input  wiscPkg::flags_t  nextFlags,
  output wiscPkg::word_t   pc,
  output wiscPkg::word_t   linkAddr,
  output logic             writeAllow,
  output logic             halted
);
  import wiscPkg::*;

  flags_t flags;
  word_t  nextPc;
  logic   condMet;

  // Sequential pc
  // jal saves this value
  assign linkAddr = pc + word_t'(1);

  // addz with Z clear retires as a no-op
  // Nothing writes once halted
  assign writeAllow = !halted && !(ctrl.condWrite && !flags.z);

  // Branch conditions on the current flags
  always_comb begin
    case (brCond)
      brNe:     condMet = !flags.z;
      brEq:     condMet = flags.z;
      brGt:     condMet = !flags.z && !flags.n;
      brLt:     condMet = flags.n;
      brGe:     condMet = flags.z || !flags.n;
      brLe:     condMet = flags.n || flags.z;
      brOv:     condMet = flags.v;
      brAlways: condMet = 1'b1;
      default:  condMet = 1'b0;
    endcase
  end

  // Next pc priority
  // Halt holds before any jump
  always_comb begin
    if (halted || ctrl.hlt) begin
      nextPc = pc;
    end else if (ctrl.jr) begin
      nextPc = jrTarget;
    end else if (ctrl.jal || (ctrl.isBranch && condMet)) begin
      nextPc = linkAddr + imm;
    end else begin
      nextPc = linkAddr;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= '0;
      flags  <= '0;
      halted <= 1'b0;
    end else begin
      pc <= nextPc;
      // Sticky until reset
      if (ctrl.hlt) begin
        halted <= 1'b1;
      end
      // Flags move with the register write for addz
      if (ctrl.setFlags && writeAllow) begin
        flags <= nextFlags;
      end
    end
  end

endmodule

/* alu.sv */
`timescale 1ns/10ps

module alu (
  input  wiscPkg::word_t  p0,
  input  wiscPkg::word_t  p1,
  input  wiscPkg::word_t  imm,
  input  logic [3:0]      shamt,
  input  wiscPkg::ctrl_t  ctrl,
  output wiscPkg::word_t  result,
  output wiscPkg::flags_t nextFlags
);
  import wiscPkg::*;

  word_t opA;
  word_t opB;
  word_t sum;
  word_t diff;
  logic  addOv;
  logic  subOv;

  // Operand A takes imm8 for lhb/llb
  assign opA = ctrl.immSrc ? imm : p0;
  // Operand B takes the memory offset for lw/sw
  assign opB = ctrl.offSrc ? imm : p1;

  // Wrapping add and subtract
  assign sum  = opA + opB;
  assign diff = opA - opB;

  // Signed overflow
  // Same-sign inputs giving the other sign on add
  assign addOv = (opA[dataW-1] == opB[dataW-1]) && (sum[dataW-1] != opA[dataW-1]);
  // Opposite-sign inputs with the sign flipping on sub
  assign subOv = (opA[dataW-1] != opB[dataW-1]) && (diff[dataW-1] != opA[dataW-1]);

  always_comb begin
    case (ctrl.aluFunc)
      aluAdd: result = sum;
      // New high byte from imm and the old low byte from p0
      aluLhb: result = {opA[7:0], p0[7:0]};
      aluSub: result = diff;
      aluAnd: result = opA & opB;
      aluNor: result = ~(opA | opB);
      aluSll: result = opA << shamt;
      aluSrl: result = opA >> shamt;
      // Arithmetic shift keeps the sign
      aluSra: result = word_t'($signed(opA) >>> shamt);
      default: result = sum;
    endcase
  end

  // Candidate flags
  // flowControl decides whether they load
  always_comb begin
    nextFlags.z = (result == '0);
    nextFlags.n = result[dataW-1];
    case (ctrl.aluFunc)
      aluAdd:  nextFlags.v = addOv;
      aluSub:  nextFlags.v = subOv;
      default: nextFlags.v = 1'b0;
    endcase
  end

endmodule

/* regFile.sv */
`timescale 1ns/10ps

module regFile (
  input  logic              clk,
  input  logic              rstN,
  input  wiscPkg::regAddr_t p0Addr,
  input  wiscPkg::regAddr_t p1Addr,
  output wiscPkg::word_t    p0,
  output wiscPkg::word_t    p1,
  input  wiscPkg::regAddr_t wrAddr,
  input  wiscPkg::word_t    wrData,
  input  logic              regWe,
  input  logic              writeAllow
);
  import wiscPkg::*;

  word_t regs [regCnt];

  // Write at the edge
  // R0 is never written
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < regCnt; i++) begin
        regs[i] <= '0;
      end
    end else if (regWe && writeAllow && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Combinational reads
  // R0 forced to zero
  assign p0 = (p0Addr == '0) ? '0 : regs[p0Addr];
  assign p1 = (p1Addr == '0) ? '0 : regs[p1Addr];

endmodule

/* instrDecode.sv */
`timescale 1ns/10ps

module instrDecode (
  input  wiscPkg::word_t    instr,
  output wiscPkg::regAddr_t p0Addr,
  output wiscPkg::regAddr_t p1Addr,
  output wiscPkg::regAddr_t regAddr,
  output wiscPkg::word_t    imm,
  output logic [3:0]        shamt,
  output wiscPkg::brCond_t  brCond,
  output wiscPkg::ctrl_t    ctrl
);
  import wiscPkg::*;

  opcode_t op;

  assign op = opcode_t'(instr[15:12]);

  // Source 0 is the destination for lhb so its low byte can be kept
  assign p0Addr = (op == opLhb) ? instr[11:8] : instr[7:4];

  // sw reads its data register through port 1
  // llb adds to R0
  always_comb begin
    case (op)
      opSw:    p1Addr = instr[11:8];
      opLlb:   p1Addr = '0;
      default: p1Addr = instr[3:0];
    endcase
  end

  assign regAddr = (op == opJal) ? regAddr_t'(linkReg) : instr[11:8];

  // Shift amount sits in the low nibble
  assign shamt  = instr[3:0];
  assign brCond = brCond_t'(instr[11:9]);

  // Immediate formats, all sign extended
  always_comb begin
    case (op)
      opLw, opSw:   imm = {{(dataW-4){instr[3]}}, instr[3:0]};
      opLhb, opLlb: imm = {{(dataW-8){instr[7]}}, instr[7:0]};
      opB:          imm = {{(dataW-9){instr[8]}}, instr[8:0]};
      opJal:        imm = {{(dataW-12){instr[11]}}, instr[11:0]};
      default:      imm = '0;
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.aluFunc = aluAdd;
    case (op)
      opAdd, opSub, opAnd, opNor, opSll, opSrl, opSra: begin
        // Function code comes straight from the opcode
        ctrl.aluFunc  = aluFunc_t'(instr[14:12]);
        ctrl.regWe    = 1'b1;
        ctrl.setFlags = 1'b1;
      end
      opAddz: begin
        // Plain add, write and flags gated later on Z
        ctrl.regWe     = 1'b1;
        ctrl.condWrite = 1'b1;
        ctrl.setFlags  = 1'b1;
      end
      opLw: begin
        ctrl.regWe    = 1'b1;
        ctrl.memRe    = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.offSrc   = 1'b1;
      end
      opSw: begin
        ctrl.memWe  = 1'b1;
        ctrl.offSrc = 1'b1;
      end
      opLhb: begin
        ctrl.aluFunc = aluLhb;
        ctrl.regWe   = 1'b1;
        ctrl.immSrc  = 1'b1;
      end
      opLlb: begin
        ctrl.regWe  = 1'b1;
        ctrl.immSrc = 1'b1;
      end
      // No register write on any branch
      opB:   ctrl.isBranch = 1'b1;
      opJal: begin
        ctrl.regWe = 1'b1;
        ctrl.jal   = 1'b1;
      end
      opJr:    ctrl.jr = 1'b1;
      opHlt:   ctrl.hlt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

/* wiscPkg.sv */
package wiscPkg;

  // Core dimensions
  localparam int dataW   = 16;
  localparam int regCnt  = 16;
  // Return address register for jal
  localparam int linkReg = 15;

  typedef logic [dataW-1:0] word_t;
  typedef logic [$clog2(regCnt)-1:0] regAddr_t;

  // Major opcode in instr[15:12]
  typedef enum logic [3:0] {
    opAdd  = 4'b0000,
    opAddz = 4'b0001,
    opSub  = 4'b0010,
    opAnd  = 4'b0011,
    opNor  = 4'b0100,
    opSll  = 4'b0101,
    opSrl  = 4'b0110,
    opSra  = 4'b0111,
    opLw   = 4'b1000,
    opSw   = 4'b1001,
    opLhb  = 4'b1010,
    opLlb  = 4'b1011,
    opB    = 4'b1100,
    opJal  = 4'b1101,
    opJr   = 4'b1110,
    opHlt  = 4'b1111
  } opcode_t;

  // ALU function select
  // Matches instr[14:12] for the 0xxx group
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluLhb = 3'd1,
    aluSub = 3'd2,
    aluAnd = 3'd3,
    aluNor = 3'd4,
    aluSll = 3'd5,
    aluSrl = 3'd6,
    aluSra = 3'd7
  } aluFunc_t;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    brNe     = 3'd0,
    brEq     = 3'd1,
    brGt     = 3'd2,
    brLt     = 3'd3,
    brGe     = 3'd4,
    brLe     = 3'd5,
    brOv     = 3'd6,
    brAlways = 3'd7
  } brCond_t;

  // Decoded control bundle
  typedef struct packed {
    aluFunc_t aluFunc;
    logic     regWe;
    logic     condWrite;  // addz
    logic     memRe;
    logic     memWe;
    logic     memToReg;
    logic     immSrc;     // lhb/llb take imm8 as operand A
    logic     offSrc;     // lw/sw take the 4-bit offset as operand B
    logic     setFlags;
    logic     isBranch;
    logic     jal;
    logic     jr;
    logic     hlt;
  } ctrl_t;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // One retired instruction as seen from outside
  typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     wrEn;
    regAddr_t wrAddr;
    word_t    wrData;
  } trace_t;

endpackage
